// ==== Makefile ====
SIM  = obj_dir/Vissue_tb
SRCS = $(shell cat compile.f)

.PHONY: run clean

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

$(SIM): compile.f $(SRCS)
	verilator --binary --timing --assert --top-module issue_tb -f compile.f -o Vissue_tb

clean:
	rm -rf obj_dir

// ==== common/cpu_pkg.sv ====
package cpu_pkg;

	// datapath and ROB sizing
	localparam int XLEN      = 32;
	localparam int ROB_DEPTH = 8;
	localparam int ROB_IDX_W = $clog2(ROB_DEPTH);

	typedef logic [XLEN-1:0]      uint32_t;
	typedef logic [31:0]          instr_t;
	typedef logic [4:0]           reg_addr_t;
	typedef logic [ROB_IDX_W-1:0] rob_index_t;
	// one extra bit so a completely full ROB is representable
	typedef logic [ROB_IDX_W:0]   rob_count_t;
	typedef logic [1:0]           rs_index_t;
	typedef logic [3:0]           alu_op_t;
	typedef logic [6:0]           opcode_t;
	typedef logic [2:0]           funct3_t;
	typedef logic [6:0]           funct7_t;

	// ALU operation codes
	localparam alu_op_t ALU_ADD  = 4'd0;
	localparam alu_op_t ALU_SUB  = 4'd1;
	localparam alu_op_t ALU_SLL  = 4'd2;
	localparam alu_op_t ALU_SLT  = 4'd3;
	localparam alu_op_t ALU_SLTU = 4'd4;
	localparam alu_op_t ALU_XOR  = 4'd5;
	localparam alu_op_t ALU_SRL  = 4'd6;
	localparam alu_op_t ALU_SRA  = 4'd7;
	localparam alu_op_t ALU_OR   = 4'd8;
	localparam alu_op_t ALU_AND  = 4'd9;

	// major opcodes handled by the issue stage
	localparam opcode_t OPC_OP     = 7'b0110011;
	localparam opcode_t OPC_OP_IMM = 7'b0010011;

	// funct3 field of OP / OP-IMM
	localparam funct3_t F3_ADD  = 3'b000;
	localparam funct3_t F3_SLL  = 3'b001;
	localparam funct3_t F3_SLT  = 3'b010;
	localparam funct3_t F3_SLTU = 3'b011;
	localparam funct3_t F3_XOR  = 3'b100;
	localparam funct3_t F3_SR   = 3'b101;
	localparam funct3_t F3_OR   = 3'b110;
	localparam funct3_t F3_AND  = 3'b111;

	// alternate funct7 selects SUB and SRA
	localparam funct7_t F7_BASE = 7'b0000000;
	localparam funct7_t F7_ALT  = 7'b0100000;

endpackage

// ==== compile.f ====
common/cpu_pkg.sv
issue/decoder.sv
issue/dispatcher.sv
issue/instr_issue.sv
verilog/reg_status_file.sv
verilog/rob_alloc.sv
verilog/issue_top.sv
test/issue_assert.sv
test/issue_tb.sv

// ==== issue/decoder.sv ====
`timescale 1ns/1ps

module decoder (
	input  cpu_pkg::instr_t    instr,
	output cpu_pkg::reg_addr_t rd,
	output cpu_pkg::reg_addr_t rs1,
	output cpu_pkg::reg_addr_t rs2,
	output cpu_pkg::uint32_t   imm,
	output logic               use_imm,
	output cpu_pkg::alu_op_t   alu_op,
	output logic               legal
);

	import cpu_pkg::*;

	opcode_t opcode;
	funct3_t funct3;
	funct7_t funct7;
	logic    is_alu;
	logic    alt;
	logic    f7_ok;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	assign rd  = instr[11:7];
	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];

	// I-type immediate, sign extended
	assign imm = {{(XLEN-12){instr[31]}}, instr[31:20]};

	assign is_alu  = (opcode == OPC_OP) || (opcode == OPC_OP_IMM);
	assign use_imm = (opcode == OPC_OP_IMM);
	assign alt     = (funct7 == F7_ALT);

	always_comb begin
		alu_op = ALU_ADD;
		case (funct3)
			// ADDI has no subtract form
			F3_ADD:  alu_op = (alt && !use_imm) ? ALU_SUB : ALU_ADD;
			F3_SLL:  alu_op = ALU_SLL;
			F3_SLT:  alu_op = ALU_SLT;
			F3_SLTU: alu_op = ALU_SLTU;
			F3_XOR:  alu_op = ALU_XOR;
			F3_SR:   alu_op = alt ? ALU_SRA : ALU_SRL;
			F3_OR:   alu_op = ALU_OR;
			F3_AND:  alu_op = ALU_AND;
			default: alu_op = ALU_ADD;
		endcase
	end

	// for OP-IMM only the shifts carry funct7 bits
	always_comb begin
		if (use_imm) begin
			if (funct3 == F3_SLL)
				f7_ok = (funct7 == F7_BASE);
			else if (funct3 == F3_SR)
				f7_ok = (funct7 == F7_BASE) || alt;
			else
				f7_ok = 1'b1;
		end else begin
			f7_ok = (funct7 == F7_BASE) || (alt && (funct3 == F3_ADD || funct3 == F3_SR));
		end
	end

	assign legal = is_alu && f7_ok;

endmodule

// ==== issue/dispatcher.sv ====
`timescale 1ns/1ps

module dispatcher (
	input  logic                       valid,
	input  logic                       legal,
	input  logic                       use_imm,
	input  cpu_pkg::alu_op_t           alu_op,
	input  cpu_pkg::uint32_t           imm,
	input  cpu_pkg::rob_index_t        reorder,

	// source operands with 0 for rs1 and 1 for rs2
	input  cpu_pkg::uint32_t     [1:0] rdata,
	input  logic                 [1:0] status_busy,
	input  cpu_pkg::rob_index_t  [1:0] status_tag,

	// ALU reservation slot
	input  logic                       alu_ready,
	input  cpu_pkg::rs_index_t         alu_index,
	output logic                       alu_taken,

	// reservation station entry
	output cpu_pkg::rs_index_t         rs_slot,
	output cpu_pkg::alu_op_t           rs_op,
	output cpu_pkg::uint32_t           rs_vj,
	output cpu_pkg::uint32_t           rs_vk,
	output cpu_pkg::rob_index_t        rs_qj,
	output cpu_pkg::rob_index_t        rs_qk,
	output logic                       rs_j_ready,
	output logic                       rs_k_ready,
	output cpu_pkg::rob_index_t        rs_tag
);

	// valid already carries rob_full and in-order gating
	assign alu_taken = valid & legal & alu_ready;

	assign rs_slot = alu_index;
	assign rs_op   = alu_op;
	assign rs_tag  = reorder;

	// first operand always from rs1
	assign rs_j_ready = ~status_busy[0];
	assign rs_vj      = status_busy[0] ? '0 : rdata[0];
	assign rs_qj      = status_busy[0] ? status_tag[0] : '0;

	// second operand from the immediate or rs2
	assign rs_k_ready = use_imm | ~status_busy[1];

	always_comb begin
		if (use_imm)
			rs_vk = imm;
		else if (status_busy[1])
			rs_vk = '0;
		else
			rs_vk = rdata[1];
	end

	// tag only meaningful while waiting
	assign rs_qk = rs_k_ready ? '0 : status_tag[1];

endmodule

// ==== issue/instr_issue.sv ====
`timescale 1ns/1ps

module instr_issue (
	// fetch side
	input  logic                      [1:0] fetch_valid,
	input  cpu_pkg::instr_t           [1:0] fetch_instr,
	output logic                      [1:0] fetch_ack,

	// ROB
	input  logic                            rob_full,
	input  cpu_pkg::rob_index_t       [1:0] rob_tag,
	output logic                      [1:0] rob_valid,
	output cpu_pkg::reg_addr_t        [1:0] rob_rd,

	// ALU slots
	input  logic                      [1:0] alu_ready,
	input  cpu_pkg::rs_index_t        [1:0] alu_index,
	output logic                      [1:0] alu_taken,

	// reservation station entries
	output cpu_pkg::rs_index_t        [1:0] rs_slot,
	output cpu_pkg::alu_op_t          [1:0] rs_op,
	output cpu_pkg::uint32_t          [1:0] rs_vj,
	output cpu_pkg::uint32_t          [1:0] rs_vk,
	output cpu_pkg::rob_index_t       [1:0] rs_qj,
	output cpu_pkg::rob_index_t       [1:0] rs_qk,
	output logic                      [1:0] rs_j_ready,
	output logic                      [1:0] rs_k_ready,
	output cpu_pkg::rob_index_t       [1:0] rs_tag,

	// register file reads
	output cpu_pkg::reg_addr_t        [3:0] reg_raddr,
	input  cpu_pkg::uint32_t          [3:0] reg_rdata,
	input  logic                      [3:0] reg_busy,
	input  cpu_pkg::rob_index_t       [3:0] reg_tag,

	// register status writes
	output logic                      [1:0] status_we,
	output cpu_pkg::reg_addr_t        [1:0] status_waddr,
	output cpu_pkg::rob_index_t       [1:0] status_tag
);

	import cpu_pkg::*;

	reg_addr_t  [1:0]      dec_rd;
	reg_addr_t  [1:0]      dec_rs1;
	reg_addr_t  [1:0]      dec_rs2;
	uint32_t    [1:0]      dec_imm;
	logic       [1:0]      dec_use_imm;
	alu_op_t    [1:0]      dec_op;
	logic       [1:0]      dec_legal;

	logic       [1:0]      disp_valid;
	logic       [1:0]      disp_ready;
	rs_index_t  [1:0]      disp_index;
	uint32_t    [1:0][1:0] src_data;
	logic       [1:0][1:0] src_busy;
	rob_index_t [1:0][1:0] src_tag;
	logic                  issue0;
	logic                  fwd_ok;

	// older instruction goes when it holds slot 0 and the ROB has room
	assign issue0 = fetch_valid[0] & ~rob_full & dec_legal[0] & alu_ready[0];

	// instruction 1 only goes along with instruction 0
	assign disp_valid[0] = fetch_valid[0] & ~rob_full;
	assign disp_valid[1] = fetch_valid[1] & ~rob_full & issue0;

	// slot 1 if free, else slot 0 when the older one left it
	assign disp_ready[0] = alu_ready[0];
	assign disp_index[0] = alu_index[0];
	assign disp_ready[1] = alu_ready[1] | (alu_ready[0] & ~issue0);
	assign disp_index[1] = alu_ready[1] ? alu_index[1] : alu_index[0];

	assign fwd_ok = issue0 && (dec_rd[0] != '0);

	// instruction 1 sees the older destination as busy
	always_comb begin
		src_data[0] = reg_rdata[1:0];
		src_busy[0] = reg_busy[1:0];
		src_tag[0]  = reg_tag[1:0];
		src_data[1] = reg_rdata[3:2];
		src_busy[1] = reg_busy[3:2];
		src_tag[1]  = reg_tag[3:2];
		if (fwd_ok && dec_rd[0] == dec_rs1[1]) begin
			src_busy[1][0] = 1'b1;
			src_tag[1][0]  = rob_tag[0];
		end
		if (fwd_ok && dec_rd[0] == dec_rs2[1]) begin
			src_busy[1][1] = 1'b1;
			src_tag[1][1]  = rob_tag[0];
		end
	end

	for (genvar i = 0; i < 2; i++) begin : gen_slot
		decoder u_decoder (
			.instr   ( fetch_instr[i] ),
			.rd      ( dec_rd[i]      ),
			.rs1     ( dec_rs1[i]     ),
			.rs2     ( dec_rs2[i]     ),
			.imm     ( dec_imm[i]     ),
			.use_imm ( dec_use_imm[i] ),
			.alu_op  ( dec_op[i]      ),
			.legal   ( dec_legal[i]   )
		);

		dispatcher u_dispatcher (
			.valid       ( disp_valid[i]  ),
			.legal       ( dec_legal[i]   ),
			.use_imm     ( dec_use_imm[i] ),
			.alu_op      ( dec_op[i]      ),
			.imm         ( dec_imm[i]     ),
			.reorder     ( rob_tag[i]     ),
			.rdata       ( src_data[i]    ),
			.status_busy ( src_busy[i]    ),
			.status_tag  ( src_tag[i]     ),
			.alu_ready   ( disp_ready[i]  ),
			.alu_index   ( disp_index[i]  ),
			.alu_taken   ( alu_taken[i]   ),
			.rs_slot     ( rs_slot[i]     ),
			.rs_op       ( rs_op[i]       ),
			.rs_vj       ( rs_vj[i]       ),
			.rs_vk       ( rs_vk[i]       ),
			.rs_qj       ( rs_qj[i]       ),
			.rs_qk       ( rs_qk[i]       ),
			.rs_j_ready  ( rs_j_ready[i]  ),
			.rs_k_ready  ( rs_k_ready[i]  ),
			.rs_tag      ( rs_tag[i]      )
		);

		assign reg_raddr[i*2]   = dec_rs1[i];
		assign reg_raddr[i*2+1] = dec_rs2[i];

		// x0 never gets a busy mark
		assign status_we[i]    = alu_taken[i] & (dec_rd[i] != '0);
		assign status_waddr[i] = dec_rd[i];
		assign status_tag[i]   = rob_tag[i];
	end

	assign rob_valid = alu_taken;
	assign rob_rd    = dec_rd;
	assign fetch_ack = {1'b0, alu_taken[0]} + {1'b0, alu_taken[1]};

endmodule

// ==== test/issue_assert.sv ====
`timescale 1ns/1ps

module issue_assert (
	input logic       clk,
	input logic       rst_n,
	input logic [1:0] fetch_valid,
	input logic [1:0] fetch_ack,
	input logic [1:0] alu_taken,
	input logic       rob_full
);

	// never acknowledge more than fetch offered
	ack_bounded: assert property (@(posedge clk) disable iff (!rst_n)
		fetch_ack <= 2'($countones(fetch_valid)))
		else $error("fetch_ack exceeds the number of valid fetch slots");

	// younger instruction only goes together with the older one
	in_order: assert property (@(posedge clk) disable iff (!rst_n)
		alu_taken[1] |-> alu_taken[0])
		else $error("second instruction issued without the first");

	full_blocks: assert property (@(posedge clk) disable iff (!rst_n)
		rob_full |-> (alu_taken == 2'b00))
		else $error("instruction issued while the ROB was full");

endmodule

bind issue_top issue_assert u_issue_assert (
	.clk         ( clk         ),
	.rst_n       ( rst_n       ),
	.fetch_valid ( fetch_valid ),
	.fetch_ack   ( fetch_ack   ),
	.alu_taken   ( alu_taken   ),
	.rob_full    ( rob_full    )
);

// ==== test/issue_tb.sv ====
`timescale 1ns/1ps

module issue_tb;

	import cpu_pkg::*;

	localparam int RESET_CYCLES = 5;
	localparam int N_DUAL       = 400;
	localparam int N_HAZARD     = 400;
	localparam int N_BACKPR     = 400;
	localparam int N_COMMIT     = 400;
	localparam int N_WRAP       = 1500;
	localparam int TOTAL_CYCLES = RESET_CYCLES + N_DUAL + N_HAZARD + N_BACKPR + N_COMMIT + N_WRAP;
	localparam int TIMEOUT_NS   = (TOTAL_CYCLES + 100) * 8;

	logic                  clk;
	logic                  rst_n;
	logic            [1:0] fetch_valid;
	instr_t          [1:0] fetch_instr;
	logic            [1:0] fetch_ack;
	logic            [1:0] alu_ready;
	rs_index_t       [1:0] alu_index;
	logic            [1:0] alu_taken;
	rs_index_t       [1:0] rs_slot;
	alu_op_t         [1:0] rs_op;
	uint32_t         [1:0] rs_vj;
	uint32_t         [1:0] rs_vk;
	rob_index_t      [1:0] rs_qj;
	rob_index_t      [1:0] rs_qk;
	logic            [1:0] rs_j_ready;
	logic            [1:0] rs_k_ready;
	rob_index_t      [1:0] rs_tag;
	logic            [1:0] rob_valid;
	reg_addr_t       [1:0] rob_rd;
	logic                  commit_valid;
	rob_index_t            commit_tag;
	reg_addr_t             commit_rd;
	uint32_t               commit_value;

	// reference model state
	uint32_t    m_val  [32];
	logic       m_busy [32];
	rob_index_t m_tag  [32];
	rob_index_t m_tail;
	rob_index_t out_tag [$];
	reg_addr_t  out_rd  [$];
	instr_t     fq      [$];

	logic [31:0] rng;
	logic [2:0]  reg_mask;
	int          tests;
	int          checks;
	int          errors;

	issue_top u_dut (.*);

	always #4 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] rand32();
		rng = xorshift(rng);
		return rng;
	endfunction

	// OP, OP-IMM and a few foreign opcodes over x0..x7
	function automatic instr_t make_instr();
		logic [31:0] r;
		logic [31:0] s;
		opcode_t     opc;
		funct7_t     f7;
		funct3_t     f3;
		reg_addr_t   rd;
		reg_addr_t   rs1;
		reg_addr_t   rs2;
		r   = rand32();
		s   = rand32();
		rd  = {2'b00, r[2:0] & reg_mask};
		rs1 = {2'b00, r[5:3] & reg_mask};
		rs2 = {2'b00, r[8:6] & reg_mask};
		f3  = r[23:21];
		if (r[26:24] == 3'd7)
			f7 = 7'b0000001;
		else if (r[26:24] >= 3'd5)
			f7 = F7_ALT;
		else
			f7 = F7_BASE;
		if (r[31:28] < 4'd7)
			opc = OPC_OP;
		else if (r[31:28] < 4'd14)
			opc = OPC_OP_IMM;
		else
			opc = r[27] ? 7'b0000011 : 7'b1100011;
		if (opc == OPC_OP_IMM && f3 != F3_SLL && f3 != F3_SR)
			return {s[11:0], rs1, f3, rd, opc};
		return {f7, (opc == OPC_OP_IMM) ? s[4:0] : rs2, rs1, f3, rd, opc};
	endfunction

	function automatic void model_decode(input instr_t ins, output logic legal,
		output alu_op_t op, output logic use_imm, output uint32_t imm);
		funct7_t f7;
		logic    r_type;
		logic    f7_any;
		f7      = ins[31:25];
		r_type  = (ins[6:0] == OPC_OP);
		use_imm = (ins[6:0] == OPC_OP_IMM);
		imm     = {{20{ins[31]}}, ins[31:20]};
		f7_any  = (f7 == F7_BASE) || (f7 == F7_ALT);
		// most funct3 values allow only a zero funct7 in R form
		legal = use_imm || (f7 == F7_BASE);
		case (ins[14:12])
			F3_ADD: begin
				op    = (r_type && f7 == F7_ALT) ? ALU_SUB : ALU_ADD;
				legal = use_imm || f7_any;
			end
			F3_SLL: begin
				op    = ALU_SLL;
				legal = (f7 == F7_BASE);
			end
			F3_SR: begin
				op    = (f7 == F7_ALT) ? ALU_SRA : ALU_SRL;
				legal = f7_any;
			end
			F3_SLT:  op = ALU_SLT;
			F3_SLTU: op = ALU_SLTU;
			F3_XOR:  op = ALU_XOR;
			F3_OR:   op = ALU_OR;
			default: op = ALU_AND;
		endcase
		legal = legal && (r_type || use_imm);
	endfunction

	// operand lookup with the older instruction of the pair taking precedence
	function automatic void resolve(input reg_addr_t r, input logic fwd, input reg_addr_t fwd_rd,
		input rob_index_t fwd_tag, output logic rdy, output uint32_t val, output rob_index_t tg);
		rdy = 1'b0;
		val = '0;
		tg  = '0;
		if (fwd && fwd_rd != '0 && r == fwd_rd)
			tg = fwd_tag;
		else if (r != '0 && m_busy[r])
			tg = m_tag[r];
		else begin
			rdy = 1'b1;
			val = (r == '0) ? '0 : m_val[r];
		end
	endfunction

	task automatic expect_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("ERR t=%0t %s: got %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic drive_inputs(input logic [3:0] both_w, input logic [3:0] alu_miss,
		input logic [3:0] commit_w);
		logic [31:0] r;
		while (fq.size() < 2)
			fq.push_back(make_instr());
		r = rand32();
		fetch_valid[0] <= (r[5:4] != 2'd0);
		fetch_valid[1] <= (r[5:4] != 2'd0) && (r[3:0] < both_w);
		fetch_instr[0] <= fq[0];
		fetch_instr[1] <= fq[1];
		alu_ready[0]   <= (r[11:8] >= alu_miss);
		alu_ready[1]   <= (r[15:12] >= alu_miss);
		alu_index[0]   <= r[17:16];
		alu_index[1]   <= r[19:18];
		// retire in order from the oldest outstanding entry
		if (out_tag.size() > 0 && r[23:20] < commit_w) begin
			commit_valid <= 1'b1;
			commit_tag   <= out_tag[0];
			commit_rd    <= out_rd[0];
			commit_value <= rand32();
		end else begin
			commit_valid <= 1'b0;
		end
	endtask

	task automatic check_and_update();
		logic       full;
		logic       avail1;
		logic       lg  [2];
		logic       ui  [2];
		logic       iss [2];
		alu_op_t    op  [2];
		uint32_t    imm [2];
		reg_addr_t  rd  [2];
		logic [1:0] exp_ack;
		rob_index_t etag;
		rs_index_t  eslot;
		logic       jr;
		logic       kr;
		uint32_t    jv;
		uint32_t    kv;
		rob_index_t jq;
		rob_index_t kq;
		full = (out_tag.size() >= ROB_DEPTH - 1);
		for (int i = 0; i < 2; i++) begin
			model_decode(fetch_instr[i], lg[i], op[i], ui[i], imm[i]);
			rd[i] = fetch_instr[i][11:7];
		end
		iss[0]  = fetch_valid[0] && lg[0] && !full && alu_ready[0];
		avail1  = alu_ready[1] || (alu_ready[0] && !iss[0]);
		iss[1]  = iss[0] && fetch_valid[1] && lg[1] && !full && avail1;
		exp_ack = {1'b0, iss[0]} + {1'b0, iss[1]};

		expect_eq("fetch_ack", 32'(fetch_ack), 32'(exp_ack));
		expect_eq("alu_taken", 32'(alu_taken), {30'd0, iss[1], iss[0]});
		expect_eq("rob_valid", 32'(rob_valid), {30'd0, iss[1], iss[0]});
		expect_eq("rob_full", 32'(u_dut.rob_full), 32'(full));

		for (int i = 0; i < 2; i++) begin
			if (iss[i]) begin
				etag  = m_tail + rob_index_t'(i);
				eslot = (i == 1 && alu_ready[1]) ? alu_index[1] : alu_index[0];
				resolve(fetch_instr[i][19:15], i == 1, rd[0], m_tail, jr, jv, jq);
				if (ui[i]) begin
					kr = 1'b1;
					kv = imm[i];
					kq = '0;
				end else begin
					resolve(fetch_instr[i][24:20], i == 1, rd[0], m_tail, kr, kv, kq);
				end
				expect_eq($sformatf("rs_slot[%0d]", i), 32'(rs_slot[i]), 32'(eslot));
				expect_eq($sformatf("rs_op[%0d]", i), 32'(rs_op[i]), 32'(op[i]));
				expect_eq($sformatf("rs_tag[%0d]", i), 32'(rs_tag[i]), 32'(etag));
				expect_eq($sformatf("rob_rd[%0d]", i), 32'(rob_rd[i]), 32'(rd[i]));
				expect_eq($sformatf("rs_j_ready[%0d]", i), 32'(rs_j_ready[i]), 32'(jr));
				if (jr)
					expect_eq($sformatf("rs_vj[%0d]", i), rs_vj[i], jv);
				else
					expect_eq($sformatf("rs_qj[%0d]", i), 32'(rs_qj[i]), 32'(jq));
				expect_eq($sformatf("rs_k_ready[%0d]", i), 32'(rs_k_ready[i]), 32'(kr));
				if (kr)
					expect_eq($sformatf("rs_vk[%0d]", i), rs_vk[i], kv);
				else
					expect_eq($sformatf("rs_qk[%0d]", i), 32'(rs_qk[i]), 32'(kq));
			end
		end

		// model state for the coming edge with commit first so a same-cycle issue wins
		if (commit_valid) begin
			if (commit_rd != '0) begin
				m_val[commit_rd] = commit_value;
				if (m_busy[commit_rd] && m_tag[commit_rd] == commit_tag)
					m_busy[commit_rd] = 1'b0;
			end
			void'(out_tag.pop_front());
			void'(out_rd.pop_front());
		end
		for (int i = 0; i < 2; i++) begin
			if (iss[i]) begin
				etag = m_tail + rob_index_t'(i);
				if (rd[i] != '0) begin
					m_busy[rd[i]] = 1'b1;
					m_tag[rd[i]]  = etag;
				end
				out_tag.push_back(etag);
				out_rd.push_back(rd[i]);
				void'(fq.pop_front());
			end
		end
		m_tail = m_tail + rob_index_t'(exp_ack);
		// fetch gives up on an illegal head once it has been offered
		if (fetch_valid[0] && !lg[0])
			void'(fq.pop_front());
	endtask

	task automatic run_test(input string name, input int cycles, input logic [3:0] both_w,
		input logic [3:0] alu_miss, input logic [3:0] commit_w, input logic [2:0] mask);
		int start_err;
		start_err = errors;
		reg_mask  = mask;
		for (int c = 0; c < cycles; c++) begin
			@(posedge clk);
			drive_inputs(both_w, alu_miss, commit_w);
			@(negedge clk);
			check_and_update();
		end
		tests++;
		$display("test %s %0d cycles, %0d errors", name, cycles, errors - start_err);
	endtask

	initial begin
		#(TIMEOUT_NS);
		$display("watchdog: simulation did not finish in the expected time");
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		rng          = 32'h8538_c6cf;
		reg_mask     = 3'b111;
		tests        = 0;
		checks       = 0;
		errors       = 0;
		m_tail       = '0;
		clk          = 1'b0;
		rst_n        <= 1'b0;
		fetch_valid  <= '0;
		fetch_instr  <= '0;
		alu_ready    <= '0;
		alu_index    <= '0;
		commit_valid <= 1'b0;
		commit_tag   <= '0;
		commit_rd    <= '0;
		commit_value <= '0;
		for (int r = 0; r < 32; r++) begin
			m_val[r]  = '0;
			m_busy[r] = 1'b0;
			m_tag[r]  = '0;
		end
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;

		run_test("dual_issue", N_DUAL, 4'd14, 4'd0, 4'd15, 3'b111);
		// few registers so pairs collide often
		run_test("hazards", N_HAZARD, 4'd14, 4'd0, 4'd8, 3'b011);
		run_test("backpressure", N_BACKPR, 4'd12, 4'd6, 4'd3, 3'b111);
		run_test("commit", N_COMMIT, 4'd8, 4'd2, 4'd14, 3'b001);
		run_test("rob_wrap", N_WRAP, 4'd12, 4'd1, 4'd9, 3'b111);

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// ==== verilog/issue_top.sv ====
`timescale 1ns/1ps

module issue_top (
	input  logic                          clk,
	input  logic                          rst_n,

	// fetch
	input  logic                    [1:0] fetch_valid,
	input  cpu_pkg::instr_t         [1:0] fetch_instr,
	output logic                    [1:0] fetch_ack,

	// ALU slots
	input  logic                    [1:0] alu_ready,
	input  cpu_pkg::rs_index_t      [1:0] alu_index,
	output logic                    [1:0] alu_taken,

	// reservation station entries
	output cpu_pkg::rs_index_t      [1:0] rs_slot,
	output cpu_pkg::alu_op_t        [1:0] rs_op,
	output cpu_pkg::uint32_t        [1:0] rs_vj,
	output cpu_pkg::uint32_t        [1:0] rs_vk,
	output cpu_pkg::rob_index_t     [1:0] rs_qj,
	output cpu_pkg::rob_index_t     [1:0] rs_qk,
	output logic                    [1:0] rs_j_ready,
	output logic                    [1:0] rs_k_ready,
	output cpu_pkg::rob_index_t     [1:0] rs_tag,

	// ROB records
	output logic                    [1:0] rob_valid,
	output cpu_pkg::reg_addr_t      [1:0] rob_rd,

	// commit
	input  logic                          commit_valid,
	input  cpu_pkg::rob_index_t           commit_tag,
	input  cpu_pkg::reg_addr_t            commit_rd,
	input  cpu_pkg::uint32_t              commit_value
);

	import cpu_pkg::*;

	reg_addr_t  [3:0] reg_raddr;
	uint32_t    [3:0] reg_rdata;
	logic       [3:0] reg_busy;
	rob_index_t [3:0] reg_tag;
	logic       [1:0] status_we;
	reg_addr_t  [1:0] status_waddr;
	rob_index_t [1:0] status_tag;
	logic             rob_full;
	rob_index_t [1:0] rob_tag;

	instr_issue u_issue (
		.fetch_valid  ( fetch_valid  ),
		.fetch_instr  ( fetch_instr  ),
		.fetch_ack    ( fetch_ack    ),
		.rob_full     ( rob_full     ),
		.rob_tag      ( rob_tag      ),
		.rob_valid    ( rob_valid    ),
		.rob_rd       ( rob_rd       ),
		.alu_ready    ( alu_ready    ),
		.alu_index    ( alu_index    ),
		.alu_taken    ( alu_taken    ),
		.rs_slot      ( rs_slot      ),
		.rs_op        ( rs_op        ),
		.rs_vj        ( rs_vj        ),
		.rs_vk        ( rs_vk        ),
		.rs_qj        ( rs_qj        ),
		.rs_qk        ( rs_qk        ),
		.rs_j_ready   ( rs_j_ready   ),
		.rs_k_ready   ( rs_k_ready   ),
		.rs_tag       ( rs_tag       ),
		.reg_raddr    ( reg_raddr    ),
		.reg_rdata    ( reg_rdata    ),
		.reg_busy     ( reg_busy     ),
		.reg_tag      ( reg_tag      ),
		.status_we    ( status_we    ),
		.status_waddr ( status_waddr ),
		.status_tag   ( status_tag   )
	);

	reg_status_file u_regs (
		.clk          ( clk          ),
		.rst_n        ( rst_n        ),
		.raddr        ( reg_raddr    ),
		.rdata        ( reg_rdata    ),
		.busy         ( reg_busy     ),
		.tag          ( reg_tag      ),
		.status_we    ( status_we    ),
		.status_waddr ( status_waddr ),
		.status_tag   ( status_tag   ),
		.commit_valid ( commit_valid ),
		.commit_rd    ( commit_rd    ),
		.commit_tag   ( commit_tag   ),
		.commit_value ( commit_value )
	);

	// allocation count is simply the number issued
	rob_alloc u_rob (
		.clk          ( clk          ),
		.rst_n        ( rst_n        ),
		.alloc_count  ( fetch_ack    ),
		.commit_valid ( commit_valid ),
		.tag          ( rob_tag      ),
		.rob_full     ( rob_full     )
	);

endmodule

// ==== verilog/reg_status_file.sv ====
`timescale 1ns/1ps

module reg_status_file (
	input  logic                          clk,
	input  logic                          rst_n,

	// combinational read ports
	input  cpu_pkg::reg_addr_t      [3:0] raddr,
	output cpu_pkg::uint32_t        [3:0] rdata,
	output logic                    [3:0] busy,
	output cpu_pkg::rob_index_t     [3:0] tag,

	// status writes from issue
	input  logic                    [1:0] status_we,
	input  cpu_pkg::reg_addr_t      [1:0] status_waddr,
	input  cpu_pkg::rob_index_t     [1:0] status_tag,

	// commit port
	input  logic                          commit_valid,
	input  cpu_pkg::reg_addr_t            commit_rd,
	input  cpu_pkg::rob_index_t           commit_tag,
	input  cpu_pkg::uint32_t              commit_value
);

	import cpu_pkg::*;

	uint32_t    value_q [32];
	logic       busy_q  [32];
	rob_index_t tag_q   [32];

	logic       commit_clear;

	// only the youngest writer may release the register
	assign commit_clear = busy_q[commit_rd] && (tag_q[commit_rd] == commit_tag);

	// entry 0 is never written, so x0 reads zero and idle
	for (genvar i = 0; i < 4; i++) begin : gen_read
		assign rdata[i] = value_q[raddr[i]];
		assign busy[i]  = busy_q[raddr[i]];
		assign tag[i]   = tag_q[raddr[i]];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int r = 0; r < 32; r++) begin
				value_q[r] <= '0;
				busy_q[r]  <= 1'b0;
				tag_q[r]   <= '0;
			end
		end else begin
			if (commit_valid && commit_rd != '0) begin
				value_q[commit_rd] <= commit_value;
				if (commit_clear)
					busy_q[commit_rd] <= 1'b0;
			end
			// issue writes after the commit and slot 1 last so it wins
			for (int s = 0; s < 2; s++) begin
				if (status_we[s] && status_waddr[s] != '0) begin
					busy_q[status_waddr[s]] <= 1'b1;
					tag_q[status_waddr[s]]  <= status_tag[s];
				end
			end
		end
	end

endmodule

// ==== verilog/rob_alloc.sv ====
`timescale 1ns/1ps

module rob_alloc (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                   [1:0] alloc_count,
	input  logic                         commit_valid,
	output cpu_pkg::rob_index_t    [1:0] tag,
	output logic                         rob_full
);

	import cpu_pkg::*;

	// fewer than two free entries blocks a whole pair
	localparam rob_count_t FULL_LEVEL = rob_count_t'(ROB_DEPTH - 1);

	rob_index_t tail_q;
	rob_count_t count_q;
	rob_count_t count_d;
	rob_index_t tail_d;

	// depth is a power of two, so the tag wraps on its own
	assign tag[0] = tail_q;
	assign tag[1] = tail_q + rob_index_t'(1);

	assign tail_d  = tail_q + rob_index_t'(alloc_count);
	assign count_d = count_q + rob_count_t'(alloc_count) - rob_count_t'(commit_valid);

	assign rob_full = (count_q >= FULL_LEVEL);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tail_q  <= '0;
			count_q <= '0;
		end else begin
			tail_q  <= tail_d;
			count_q <= count_d;
		end
	end

endmodule
